//--- tb/program_patterns.txt
# tag (I instruction, D data word, E expected store), byte address, hex word
I 00000000 20101234  ldi r1, 0x1234
I 00000004 50100100  st r1, [r0+0x100]
I 00000008 2020FFFF  ldi r2, 0xffff
I 0000000C 50200104  st r2, [r0+0x104]
I 00000010 10312000  add r3, r1, r2
I 00000014 50300108  st r3, [r0+0x108]
I 00000018 11412000  sub r4, r1, r2
I 0000001C 5040010C  st r4, [r0+0x10c]
I 00000020 12532000  and r5, r3, r2
I 00000024 50500110  st r5, [r0+0x110]
I 00000028 13613000  or r6, r1, r3
I 0000002C 50600114  st r6, [r0+0x114]
I 00000030 14742000  xor r7, r4, r2
I 00000034 50700118  st r7, [r0+0x118]
I 00000038 10811000  add r8, r1, r1
I 0000003C 10981000  add r9, r8, r1
I 00000040 30A90000  mov r10, r9
I 00000044 50A0011C  st r10, [r0+0x11c]
I 00000048 20B00090  ldi r11, 0x90
I 0000004C 40CBFFF0  ld r12, [r11-0x10]
I 00000050 10DC1000  add r13, r12, r1
I 00000054 50DB0010  st r13, [r11+0x10]
I 00000058 F0000000  halt
D 00000080 CAFEBABE
E 00000100 00001234
E 00000104 0000FFFF
E 00000108 00011233
E 0000010C FFFF1235
E 00000110 00001233
E 00000114 00011237
E 00000118 FFFFEDCA
E 0000011C 0000369C
E 000000A0 CAFECCF2

//--- vlog.f
logic/cpu_pkg.sv
logic/fetch_unit.sv
logic/register_file.sv
logic/idecode.sv
logic/execute_mem.sv
logic/cpu_core.sv
tb/tb_cpu_core.sv

//--- Bender.yml
package:
  name: cpu_core

sources:
  - logic/cpu_pkg.sv
  - logic/fetch_unit.sv
  - logic/register_file.sv
  - logic/idecode.sv
  - logic/execute_mem.sv
  - logic/cpu_core.sv
  - target: simulation
    files:
      - tb/tb_cpu_core.sv

//--- tb/tb_cpu_core.sv
module tb_cpu_core import cpu_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int IMEM_WORDS = 64;
	localparam int DMEM_WORDS = 128;
	localparam int QUIET_CYCLES = 20;	// watch window after halt

	logic              clk_i;
	logic              rst_i;
	logic              ibus_cyc_o;
	logic              ibus_stb_o;
	logic [XLEN-1:0]   ibus_adr_o;
	logic [ILEN-1:0]   ibus_dat_i;
	logic              ibus_ack_i;
	logic              dbus_cyc_o;
	logic              dbus_stb_o;
	logic              dbus_we_o;
	logic [XLEN/8-1:0] dbus_sel_o;
	logic [XLEN-1:0]   dbus_adr_o;
	logic [XLEN-1:0]   dbus_dat_o;
	logic [XLEN-1:0]   dbus_dat_i;
	logic              dbus_ack_i;
	logic              halted_o;

	logic [ILEN-1:0] imem [IMEM_WORDS];
	logic [XLEN-1:0] dmem [DMEM_WORDS];
	logic [XLEN-1:0] exp_addr_q [$];
	logic [XLEN-1:0] exp_data_q [$];
	integer          seed = 37291;
	int              i_wait;
	int              d_wait;
	bit              i_pending;
	bit              d_pending;
	int              store_count;
	int              instr_count;
	int              limit;
	int              cycles;

	cpu_core u_cpu_core (.*);

	initial
	begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [XLEN-1:0] expected,
		input logic [XLEN-1:0] actual);
		if (actual !== expected)
			abort_run($sformatf("FAIL %s expected %08h actual %08h", name, expected, actual));
	endtask

	task automatic load_patterns();
		int          fd;
		int          n;
		string       line;
		byte         tag;
		logic [31:0] addr;
		logic [31:0] word;
		fd = $fopen("tb/program_patterns.txt", "r");
		if (fd == 0)
			abort_run("cannot open tb/program_patterns.txt");
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			n = $sscanf(line, "%c %h %h", tag, addr, word);
			if (n == 3)
			begin
				case (tag)
					"I":
					begin
						imem[addr[7:2]] = word;
						instr_count++;
					end
					"D": dmem[addr[8:2]] = word;
					"E":
					begin
						exp_addr_q.push_back(addr);
						exp_data_q.push_back(word);
					end
					default: ;	// comment line
				endcase
			end
		end
		$fclose(fd);
	endtask

	task automatic record_store();
		string tag;
		tag = $sformatf("store %0d", store_count);
		if (exp_addr_q.size() == 0)
			abort_run($sformatf("%s to %08h came after the last expected store", tag, dbus_adr_o));
		check_value({tag, " address"}, exp_addr_q[0], dbus_adr_o);
		check_value({tag, " data"}, exp_data_q[0], dbus_dat_o);
		check_value({tag, " byte selects"}, XLEN'(4'hf), XLEN'(dbus_sel_o));
		void'(exp_addr_q.pop_front());
		void'(exp_data_q.pop_front());
		dmem[dbus_adr_o[8:2]] = dbus_dat_o;
		store_count++;
	endtask

	// both slaves ack after 0 to 3 wait cycles, ack is a one-cycle pulse
	task automatic serve_buses();
		if (ibus_ack_i)
			ibus_ack_i = 1'b0;	// taken at this edge
		else if (ibus_cyc_o && ibus_stb_o)
		begin
			if (ibus_adr_o >= IMEM_WORDS * 4)
				abort_run($sformatf("instruction fetch at %08h is outside program memory", ibus_adr_o));
			if (!i_pending)
				i_wait = $unsigned($random(seed)) % 4;
			i_pending = 1'b1;
			if (i_wait == 0)
			begin
				ibus_dat_i = imem[ibus_adr_o[7:2]];
				ibus_ack_i = 1'b1;
				i_pending = 1'b0;
			end
			else
				i_wait--;
		end
		if (dbus_ack_i)
			dbus_ack_i = 1'b0;
		else if (dbus_cyc_o && dbus_stb_o)
		begin
			if (!d_pending)
				d_wait = $unsigned($random(seed)) % 4;
			d_pending = 1'b1;
			if (d_wait == 0)
			begin
				if (dbus_we_o)
					record_store();
				else
					dbus_dat_i = dmem[dbus_adr_o[8:2]];
				dbus_ack_i = 1'b1;
				d_pending = 1'b0;
			end
			else
				d_wait--;
		end
	endtask

	always @(posedge clk_i)
	begin
		#2;
		serve_buses();
	end

	initial
	begin
		rst_i = 1'b1;
		ibus_dat_i = '0;
		ibus_ack_i = 1'b0;
		dbus_dat_i = '0;
		dbus_ack_i = 1'b0;
		i_pending = 1'b0;
		d_pending = 1'b0;
		for (int i = 0; i < IMEM_WORDS; i++)
			imem[i] = {4'hf, 28'(i * 4)};	// stray fetch decodes as halt
		for (int i = 0; i < DMEM_WORDS; i++)
			dmem[i] = 32'hd000_0000 | XLEN'(i * 4);
		load_patterns();
		limit = instr_count * 16 + 50;
		repeat (5) @(posedge clk_i);
		#2;
		rst_i = 1'b0;
		cycles = 0;
		while (!halted_o && (cycles < limit))
		begin
			@(posedge clk_i);
			#2;
			cycles++;
		end
		if (!halted_o)
			abort_run($sformatf("core hung, no halt within %0d cycles", limit));
		repeat (QUIET_CYCLES)
		begin
			@(posedge clk_i);
			#2;
			if (dbus_cyc_o)
				abort_run("data bus cycle started after halt");
		end
		if (exp_addr_q.size() != 0)
			abort_run($sformatf("halted with %0d expected stores never seen", exp_addr_q.size()));
		else
		begin
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule

//--- logic/cpu_core.sv
module cpu_core import cpu_pkg::*;
(
	input  logic              clk_i,
	input  logic              rst_i,
	output logic              ibus_cyc_o,
	output logic              ibus_stb_o,
	output logic [XLEN-1:0]   ibus_adr_o,
	input  logic [ILEN-1:0]   ibus_dat_i,
	input  logic              ibus_ack_i,
	output logic              dbus_cyc_o,
	output logic              dbus_stb_o,
	output logic              dbus_we_o,
	output logic [XLEN/8-1:0] dbus_sel_o,
	output logic [XLEN-1:0]   dbus_adr_o,
	output logic [XLEN-1:0]   dbus_dat_o,
	input  logic [XLEN-1:0]   dbus_dat_i,
	input  logic              dbus_ack_i,
	output logic              halted_o
);

	logic [ILEN-1:0]    f_instr;
	logic [XLEN-1:0]    f_pc;
	logic               f_valid;
	logic               d_stall;
	logic [ILEN-1:0]    d_instr;
	logic [XLEN-1:0]    d_pc;
	logic [XLEN-1:0]    d_op_a;
	logic [XLEN-1:0]    d_op_b;
	logic               d_valid;
	logic [RADDR_W-1:0] rd_addr_a;
	logic [RADDR_W-1:0] rd_addr_b;
	logic [XLEN-1:0]    rd_data_a;
	logic [XLEN-1:0]    rd_data_b;
	logic               x_busy;
	logic               x_wr_en;
	logic [RADDR_W-1:0] x_wr_addr;
	logic               wb_en;
	logic [RADDR_W-1:0] wb_addr;
	logic [XLEN-1:0]    wb_data;

	fetch_unit u_fetch_unit (
		.clk_i(clk_i), .rst_i(rst_i),
		.ibus_cyc_o(ibus_cyc_o), .ibus_stb_o(ibus_stb_o), .ibus_adr_o(ibus_adr_o),
		.ibus_dat_i(ibus_dat_i), .ibus_ack_i(ibus_ack_i),
		.stall_i(d_stall), .halt_i(halted_o),
		.instr_o(f_instr), .pc_o(f_pc), .valid_o(f_valid)
	);

	idecode u_idecode (
		.clk_i(clk_i), .rst_i(rst_i),
		.instr_i(f_instr), .pc_i(f_pc), .valid_i(f_valid), .stall_o(d_stall),
		.x_busy_i(x_busy), .x_wr_en_i(x_wr_en), .x_wr_addr_i(x_wr_addr),
		.wb_en_i(wb_en), .wb_addr_i(wb_addr),
		.rd_addr_a_o(rd_addr_a), .rd_addr_b_o(rd_addr_b),
		.rd_data_a_i(rd_data_a), .rd_data_b_i(rd_data_b),
		.instr_o(d_instr), .pc_o(d_pc), .op_a_o(d_op_a), .op_b_o(d_op_b),
		.valid_o(d_valid)
	);

	register_file u_register_file (
		.clk_i(clk_i), .rst_i(rst_i),
		.rd_addr_a_i(rd_addr_a), .rd_addr_b_i(rd_addr_b),
		.rd_data_a_o(rd_data_a), .rd_data_b_o(rd_data_b),
		.wr_en_i(wb_en), .wr_addr_i(wb_addr), .wr_data_i(wb_data)
	);

	execute_mem u_execute_mem (
		.clk_i(clk_i), .rst_i(rst_i),
		.instr_i(d_instr), .pc_i(d_pc), .op_a_i(d_op_a), .op_b_i(d_op_b),
		.valid_i(d_valid), .busy_o(x_busy),
		.x_wr_en_o(x_wr_en), .x_wr_addr_o(x_wr_addr),
		.wb_en_o(wb_en), .wb_addr_o(wb_addr), .wb_data_o(wb_data),
		.halted_o(halted_o),
		.dbus_cyc_o(dbus_cyc_o), .dbus_stb_o(dbus_stb_o), .dbus_we_o(dbus_we_o),
		.dbus_sel_o(dbus_sel_o), .dbus_adr_o(dbus_adr_o), .dbus_dat_o(dbus_dat_o),
		.dbus_dat_i(dbus_dat_i), .dbus_ack_i(dbus_ack_i)
	);

endmodule

//--- logic/execute_mem.sv
module execute_mem import cpu_pkg::*;
(
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic [ILEN-1:0]     instr_i,
	input  logic [XLEN-1:0]     pc_i,
	input  logic [XLEN-1:0]     op_a_i,
	input  logic [XLEN-1:0]     op_b_i,
	input  logic                valid_i,
	output logic                busy_o,
	output logic                x_wr_en_o,
	output logic [RADDR_W-1:0]  x_wr_addr_o,
	output logic                wb_en_o,
	output logic [RADDR_W-1:0]  wb_addr_o,
	output logic [XLEN-1:0]     wb_data_o,
	output logic                halted_o,
	output logic                dbus_cyc_o,
	output logic                dbus_stb_o,
	output logic                dbus_we_o,
	output logic [XLEN/8-1:0]   dbus_sel_o,
	output logic [XLEN-1:0]     dbus_adr_o,
	output logic [XLEN-1:0]     dbus_dat_o,
	input  logic [XLEN-1:0]     dbus_dat_i,
	input  logic                dbus_ack_i
);

	typedef enum logic {D_IDLE, D_REQ} dbus_state_e;

	dbus_state_e        dstate;
	instr_type_e        itype;
	alu_op_e            aop;
	logic [RADDR_W-1:0] ra;
	logic [IMM_W-1:0]   imm;
	logic [XLEN-1:0]    alu_res;
	logic [XLEN-1:0]    result;
	logic [XLEN-1:0]    mem_addr;
	logic               live;
	logic               is_mem;
	logic               mem_done;

	assign itype = instr_type_e'(instr_i[TYPE_HI:TYPE_LO]);
	assign aop = alu_op_e'(instr_i[OP_HI:OP_LO]);
	assign ra = instr_i[RA_HI:RA_LO];
	assign imm = instr_i[IMM_HI:IMM_LO];

	assign live = valid_i && !halted_o;	// nothing retires past halt
	assign is_mem = live && (itype inside {T_LOAD, T_STORE});
	assign mem_done = (dstate == D_REQ) && dbus_ack_i;
	assign busy_o = halted_o || (is_mem && !mem_done);

	assign x_wr_en_o = live && (itype inside {T_ALU, T_LDI, T_MOV, T_LOAD});
	assign x_wr_addr_o = ra;

	assign mem_addr = op_a_i + {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm};

	always_comb
	begin
		case (aop)
			OP_ADD: alu_res = op_a_i + op_b_i;
			OP_SUB: alu_res = op_a_i - op_b_i;
			OP_AND: alu_res = op_a_i & op_b_i;
			OP_OR:  alu_res = op_a_i | op_b_i;
			OP_XOR: alu_res = op_a_i ^ op_b_i;
			default: alu_res = '0;
		endcase
	end

	always_comb
	begin
		case (itype)
			T_ALU: result = alu_res;
			T_LDI: result = {{(XLEN-IMM_W){1'b0}}, imm};
			default: result = op_a_i;	// mov
		endcase
	end

	assign dbus_cyc_o = (dstate == D_REQ);
	assign dbus_stb_o = (dstate == D_REQ);
	assign dbus_sel_o = '1;	// word accesses only

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			dstate <= D_IDLE;
			dbus_we_o <= 1'b0;
			wb_en_o <= 1'b0;
			halted_o <= 1'b0;
		end
		else
		begin
			case (dstate)
				D_IDLE:
					if (is_mem)
					begin
						dstate <= D_REQ;
						dbus_we_o <= (itype == T_STORE);
					end
				D_REQ:
					if (dbus_ack_i)
						dstate <= D_IDLE;
				default:
					dstate <= D_IDLE;
			endcase

			wb_en_o <= (live && (itype inside {T_ALU, T_LDI, T_MOV})) ||
				(mem_done && !dbus_we_o);

			if (live && (itype == T_HALT))
				halted_o <= 1'b1;
		end
	end

	always_ff @(posedge clk_i)
	begin
		if ((dstate == D_IDLE) && is_mem)
		begin
			dbus_adr_o <= mem_addr;
			dbus_dat_o <= op_b_i;
		end
		wb_addr_o <= ra;
		wb_data_o <= mem_done ? dbus_dat_i : result;	// load data on ack
	end

	a_we_stable: assert property (@(posedge clk_i) disable iff (rst_i)
		dbus_stb_o && !dbus_ack_i |=> $stable(dbus_we_o) && $stable(dbus_adr_o));

	// decode must keep the same instruction until the access ends
	a_mem_hold: assert property (@(posedge clk_i) disable iff (rst_i)
		is_mem && !mem_done |=> valid_i && $stable(pc_i) && $stable(instr_i));

endmodule

//--- logic/idecode.sv
module idecode import cpu_pkg::*;
(
	input  logic               clk_i,
	input  logic               rst_i,
	input  logic [ILEN-1:0]    instr_i,
	input  logic [XLEN-1:0]    pc_i,
	input  logic               valid_i,
	output logic               stall_o,
	input  logic               x_busy_i,
	input  logic               x_wr_en_i,
	input  logic [RADDR_W-1:0] x_wr_addr_i,
	input  logic               wb_en_i,
	input  logic [RADDR_W-1:0] wb_addr_i,
	output logic [RADDR_W-1:0] rd_addr_a_o,
	output logic [RADDR_W-1:0] rd_addr_b_o,
	input  logic [XLEN-1:0]    rd_data_a_i,
	input  logic [XLEN-1:0]    rd_data_b_i,
	output logic [ILEN-1:0]    instr_o,
	output logic [XLEN-1:0]    pc_o,
	output logic [XLEN-1:0]    op_a_o,
	output logic [XLEN-1:0]    op_b_o,
	output logic               valid_o
);

	instr_type_e        itype;
	logic [RADDR_W-1:0] ra;
	logic [RADDR_W-1:0] rb;
	logic [RADDR_W-1:0] rc;
	logic               use_a;
	logic               use_b;
	logic               hazard;
	logic               accept;

	assign itype = instr_type_e'(instr_i[TYPE_HI:TYPE_LO]);
	assign ra = instr_i[RA_HI:RA_LO];
	assign rb = instr_i[RB_HI:RB_LO];
	assign rc = instr_i[RC_HI:RC_LO];

	// register still owed by execute or by the writeback register
	function automatic logic pending(input logic [RADDR_W-1:0] addr);
		return (x_wr_en_i && (x_wr_addr_i == addr)) || (wb_en_i && (wb_addr_i == addr));
	endfunction

	always_comb
	begin
		rd_addr_a_o = rb;
		rd_addr_b_o = rb;
		use_a = 1'b0;
		use_b = 1'b0;
		case (itype)
			T_ALU:
			begin
				rd_addr_b_o = rc;
				use_a = 1'b1;
				use_b = 1'b1;
			end
			T_MOV, T_LOAD:
				use_a = 1'b1;	// port b repeats rb
			T_STORE:
			begin
				rd_addr_b_o = ra;	// store data
				use_a = 1'b1;
				use_b = 1'b1;
			end
			default:
			begin
				use_a = 1'b0;
				use_b = 1'b0;
			end
		endcase
	end

	always_comb
	begin
		hazard = (use_a && pending(rd_addr_a_o)) || (use_b && pending(rd_addr_b_o));
	end

	assign accept = valid_i && !hazard && !x_busy_i;
	assign stall_o = valid_i && !accept;

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			valid_o <= 1'b0;
			instr_o <= NOP_WORD;
		end
		else if (!x_busy_i)
		begin
			if (accept)
			begin
				valid_o <= 1'b1;
				instr_o <= instr_i;
			end
			else
			begin
				valid_o <= 1'b0;	// bubble
				instr_o <= NOP_WORD;
			end
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (accept)
		begin
			pc_o <= pc_i;
			op_a_o <= rd_data_a_i;
			op_b_o <= rd_data_b_i;
		end
	end

	a_valid_known: assert property (@(posedge clk_i) disable iff (rst_i)
		!$isunknown(valid_o));

endmodule

//--- logic/register_file.sv
module register_file import cpu_pkg::*;
(
	input  logic               clk_i,
	input  logic               rst_i,
	input  logic [RADDR_W-1:0] rd_addr_a_i,
	input  logic [RADDR_W-1:0] rd_addr_b_i,
	output logic [XLEN-1:0]    rd_data_a_o,
	output logic [XLEN-1:0]    rd_data_b_o,
	input  logic               wr_en_i,
	input  logic [RADDR_W-1:0] wr_addr_i,
	input  logic [XLEN-1:0]    wr_data_i
);

	logic [XLEN-1:0] regs [NREGS];

	// write-through so a landing value is visible the same cycle
	function automatic logic [XLEN-1:0] read_port(input logic [RADDR_W-1:0] addr);
		if (wr_en_i && (wr_addr_i == addr))
			return wr_data_i;
		return regs[addr];
	endfunction

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			for (int i = 0; i < NREGS; i++)
				regs[i] <= '0;
		end
		else if (wr_en_i)
			regs[wr_addr_i] <= wr_data_i;
	end

	always_comb
	begin
		rd_data_a_o = read_port(rd_addr_a_i);
		rd_data_b_o = read_port(rd_addr_b_i);
	end

endmodule

//--- logic/fetch_unit.sv
module fetch_unit import cpu_pkg::*;
(
	input  logic            clk_i,
	input  logic            rst_i,
	output logic            ibus_cyc_o,
	output logic            ibus_stb_o,
	output logic [XLEN-1:0] ibus_adr_o,
	input  logic [ILEN-1:0] ibus_dat_i,
	input  logic            ibus_ack_i,
	input  logic            stall_i,
	input  logic            halt_i,
	output logic [ILEN-1:0] instr_o,
	output logic [XLEN-1:0] pc_o,
	output logic            valid_o
);

	typedef enum logic {F_IDLE, F_REQ} fetch_state_e;

	fetch_state_e    state;
	logic [XLEN-1:0] pc;
	logic            start;
	logic            done;

	// a held word must be taken before the next read goes out
	assign start = (state == F_IDLE) && !halt_i && !(valid_o && stall_i);
	assign done = (state == F_REQ) && ibus_ack_i;

	assign ibus_cyc_o = (state == F_REQ);
	assign ibus_stb_o = (state == F_REQ);
	assign ibus_adr_o = pc;

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			state <= F_IDLE;
			pc <= RESET_PC;
			valid_o <= 1'b0;
		end
		else
		begin
			case (state)
				F_IDLE:
					if (start)
						state <= F_REQ;
				F_REQ:
					if (ibus_ack_i)
						state <= F_IDLE;	// drop cyc/stb after ack
				default:
					state <= F_IDLE;
			endcase

			if (done)
			begin
				pc <= pc + XLEN'(4);
				valid_o <= 1'b1;
			end
			else if (!stall_i)
				valid_o <= 1'b0;	// consumed by decode
		end
	end

	// holding register, stays put while stalled
	always_ff @(posedge clk_i)
	begin
		if (done)
		begin
			instr_o <= ibus_dat_i;
			pc_o <= pc;
		end
	end

	a_ibus_hold: assert property (@(posedge clk_i) disable iff (rst_i)
		ibus_stb_o && !ibus_ack_i |=> ibus_cyc_o && ibus_stb_o && $stable(ibus_adr_o));

endmodule

//--- logic/cpu_pkg.sv
package cpu_pkg;

	localparam int XLEN = 32;
	localparam int ILEN = 32;
	localparam int NREGS = 16;
	localparam int RADDR_W = 4;

	// instruction word layout
	localparam int TYPE_HI = 31;
	localparam int TYPE_LO = 28;
	localparam int OP_HI = 27;
	localparam int OP_LO = 24;
	localparam int RA_HI = 23;
	localparam int RA_LO = 20;
	localparam int RB_HI = 19;
	localparam int RB_LO = 16;
	localparam int RC_HI = 15;
	localparam int RC_LO = 12;
	localparam int IMM_W = 16;
	localparam int IMM_LO = 0;
	localparam int IMM_HI = IMM_LO + IMM_W - 1;

	typedef enum logic [3:0] {
		T_NOP   = 4'h0,
		T_ALU   = 4'h1,
		T_LDI   = 4'h2,
		T_MOV   = 4'h3,
		T_LOAD  = 4'h4,
		T_STORE = 4'h5,
		T_HALT  = 4'hf
	} instr_type_e;

	typedef enum logic [3:0] {
		OP_ADD = 4'h0,
		OP_SUB = 4'h1,
		OP_AND = 4'h2,
		OP_OR  = 4'h3,
		OP_XOR = 4'h4
	} alu_op_e;

	localparam logic [ILEN-1:0] NOP_WORD = '0;	// type nibble is T_NOP
	localparam logic [XLEN-1:0] RESET_PC = '0;

endpackage
